// ==== dpd_defines.svh ====
`ifndef DPD_DEFINES_SVH
`define DPD_DEFINES_SVH

// datapath
`define DPD_IQ_WIDTH        16
`define DPD_FRAC_BITS       14          // gain 0x4000 is unity
`define DPD_MAG_WIDTH       6
`define DPD_LUT_COUNT       4
`define DPD_LUT_SEL_WIDTH   2

// register bus
`define DPD_UP_ADDR_WIDTH   9           // bit 8 selects lut space
`define DPD_UP_DATA_WIDTH   32

`define DPD_REG_VERSION     0
`define DPD_REG_SCRATCH     1
`define DPD_REG_BYPASS      2

`define DPD_IP_VERSION      32'h0001_0161
`define DPD_ACT_LATENCY     4

`endif

// ==== dpd_pkg.sv ====
`include "dpd_defines.svh"

package dpd_pkg;

    // one complex sample or gain, i in the upper half
    typedef struct packed {
        logic signed [`DPD_IQ_WIDTH-1:0] i;
        logic signed [`DPD_IQ_WIDTH-1:0] q;
    } iq_t;

    // same lut word seen by the bus and by the multiplier
    typedef union packed {
        logic [`DPD_UP_DATA_WIDTH-1:0] raw;
        iq_t                           iq;
    } lut_word_u;

    typedef struct packed {
        logic [`DPD_LUT_COUNT-1:0] we;     // one-hot per lut
        logic [`DPD_MAG_WIDTH-1:0] addr;
        lut_word_u                 wdata;
    } lut_cfg_t;

endpackage

// ==== dpd_regs.sv ====
`timescale 1ns/1ps
`include "dpd_defines.svh"

module dpd_regs (
    input  logic                            up_clk,
    input  logic                            up_rstn,
    input  logic                            up_wreq,
    input  logic [`DPD_UP_ADDR_WIDTH-1:0]   up_waddr,
    input  logic [`DPD_UP_DATA_WIDTH-1:0]   up_wdata,
    output logic                            up_wack,
    input  logic                            up_rreq,
    input  logic [`DPD_UP_ADDR_WIDTH-1:0]   up_raddr,
    output logic [`DPD_UP_DATA_WIDTH-1:0]   up_rdata,
    output logic                            up_rack,
    output dpd_pkg::lut_cfg_t               lut_cfg,
    input  dpd_pkg::lut_word_u              cfg_rdata [`DPD_LUT_COUNT],
    output logic                            bypass
);

    logic [`DPD_UP_DATA_WIDTH-1:0]  scratch_reg;
    logic [`DPD_UP_DATA_WIDTH-1:0]  bypass_reg;

    logic [`DPD_LUT_COUNT-1:0]      wr_onehot;
    logic [`DPD_LUT_COUNT-1:0]      cfg_we;
    logic [`DPD_MAG_WIDTH-1:0]      cfg_addr;
    dpd_pkg::lut_word_u             cfg_wdata;

    logic                               rreq_d;
    logic                               rd_lut;
    logic [`DPD_LUT_SEL_WIDTH-1:0]      rd_id;
    logic [`DPD_UP_ADDR_WIDTH-2:0]      rd_off;
    logic [`DPD_UP_DATA_WIDTH-1:0]      rd_word;

    // lut id sits just above the entry bits
    always_comb begin
        for (int k = 0; k < `DPD_LUT_COUNT; k++) begin
            wr_onehot[k] = (up_waddr[`DPD_MAG_WIDTH +: `DPD_LUT_SEL_WIDTH] == k);
        end
    end

    always_ff @(posedge up_clk) begin
        if (!up_rstn) begin
            up_wack     <= 1'b0;
            cfg_we      <= '0;
            scratch_reg <= '0;
            bypass_reg  <= '0;
        end else begin
            up_wack <= up_wreq;
            cfg_we  <= '0;      // single-cycle strobe
            if (up_wreq) begin
                if (up_waddr[`DPD_UP_ADDR_WIDTH-1]) begin
                    cfg_we <= wr_onehot;
                end else if (up_waddr[`DPD_UP_ADDR_WIDTH-2:0] == `DPD_REG_SCRATCH) begin
                    scratch_reg <= up_wdata;
                end else if (up_waddr[`DPD_UP_ADDR_WIDTH-2:0] == `DPD_REG_BYPASS) begin
                    bypass_reg <= up_wdata;
                end
            end
        end
    end

    // entry address from whichever request is active
    always_ff @(posedge up_clk) begin
        if (up_wreq) begin
            cfg_addr  <= up_waddr[`DPD_MAG_WIDTH-1:0];
            cfg_wdata <= up_wdata;
        end else if (up_rreq) begin
            cfg_addr  <= up_raddr[`DPD_MAG_WIDTH-1:0];
        end
    end

    assign lut_cfg = '{we: cfg_we, addr: cfg_addr, wdata: cfg_wdata};

    // hold read address while the lut answers
    always_ff @(posedge up_clk) begin
        if (up_rreq) begin
            rd_lut <= up_raddr[`DPD_UP_ADDR_WIDTH-1];
            rd_id  <= up_raddr[`DPD_MAG_WIDTH +: `DPD_LUT_SEL_WIDTH];
            rd_off <= up_raddr[`DPD_UP_ADDR_WIDTH-2:0];
        end
    end

    always_comb begin
        if (rd_lut) begin
            rd_word = cfg_rdata[rd_id].raw;
        end else begin
            case (rd_off)
                `DPD_REG_VERSION: rd_word = `DPD_IP_VERSION;
                `DPD_REG_SCRATCH: rd_word = scratch_reg;
                `DPD_REG_BYPASS:  rd_word = bypass_reg;
                default:          rd_word = '0;     // unmapped
            endcase
        end
    end

    always_ff @(posedge up_clk) begin
        if (!up_rstn) begin
            rreq_d   <= 1'b0;
            up_rack  <= 1'b0;
            up_rdata <= '0;
        end else begin
            rreq_d   <= up_rreq;
            up_rack  <= rreq_d;
            up_rdata <= rreq_d ? rd_word : '0;
        end
    end

    assign bypass = bypass_reg[0];

endmodule

// ==== dpd_lut_row.sv ====
`timescale 1ns/1ps
`include "dpd_defines.svh"

module dpd_lut_row #(
    parameter int TAP = 0
) (
    input  logic                        up_clk,
    input  logic                        up_rstn,
    input  dpd_pkg::iq_t                tu,
    input  logic [`DPD_MAG_WIDTH-1:0]   mag,
    input  dpd_pkg::lut_cfg_t           lut_cfg,
    output dpd_pkg::lut_word_u          cfg_rdata,
    output dpd_pkg::iq_t                prod
);

    dpd_pkg::lut_word_u lut_mem [2**`DPD_MAG_WIDTH];

    dpd_pkg::iq_t                       tu_tap;
    logic [`DPD_MAG_WIDTH-1:0]          mag_tap;
    dpd_pkg::iq_t                       tu_s1;
    dpd_pkg::iq_t                       gain_s1;
    logic signed [2*`DPD_IQ_WIDTH-1:0]  p_ii;
    logic signed [2*`DPD_IQ_WIDTH-1:0]  p_qq;
    logic signed [2*`DPD_IQ_WIDTH-1:0]  p_iq;
    logic signed [2*`DPD_IQ_WIDTH-1:0]  p_qi;
    logic signed [2*`DPD_IQ_WIDTH:0]    re_sum;
    logic signed [2*`DPD_IQ_WIDTH:0]    im_sum;

    generate
        if (TAP == 0) begin : gen_nodly
            assign tu_tap  = tu;
            assign mag_tap = mag;
        end else begin : gen_dly
            dpd_pkg::iq_t              tu_dly  [TAP];
            logic [`DPD_MAG_WIDTH-1:0] mag_dly [TAP];

            always_ff @(posedge up_clk) begin
                if (!up_rstn) begin
                    for (int n = 0; n < TAP; n++) begin
                        tu_dly[n]  <= '0;
                        mag_dly[n] <= '0;
                    end
                end else begin
                    tu_dly[0]  <= tu;
                    mag_dly[0] <= mag;
                    for (int n = 1; n < TAP; n++) begin
                        tu_dly[n]  <= tu_dly[n-1];
                        mag_dly[n] <= mag_dly[n-1];
                    end
                end
            end

            assign tu_tap  = tu_dly[TAP-1];
            assign mag_tap = mag_dly[TAP-1];
        end
    endgenerate

    // config port, write plus async readback
    always_ff @(posedge up_clk) begin
        if (lut_cfg.we[TAP]) begin
            lut_mem[lut_cfg.addr] <= lut_cfg.wdata;
        end
    end

    assign cfg_rdata = lut_mem[lut_cfg.addr];

    // datapath lut read
    always_ff @(posedge up_clk) begin
        gain_s1 <= lut_mem[mag_tap].iq;
        tu_s1   <= tu_tap;
    end

    // multiply stage 1
    always_ff @(posedge up_clk) begin
        p_ii <= tu_s1.i * gain_s1.i;
        p_qq <= tu_s1.q * gain_s1.q;
        p_iq <= tu_s1.i * gain_s1.q;
        p_qi <= tu_s1.q * gain_s1.i;
    end

    always_comb begin
        re_sum = p_ii - p_qq;
        im_sum = p_iq + p_qi;
    end

    // stage 2, scale back and wrap to 16 bits
    always_ff @(posedge up_clk) begin
        if (!up_rstn) begin
            prod <= '0;
        end else begin
            prod.i <= re_sum[`DPD_FRAC_BITS +: `DPD_IQ_WIDTH];
            prod.q <= im_sum[`DPD_FRAC_BITS +: `DPD_IQ_WIDTH];
        end
    end

endmodule

// ==== dpd_combiner.sv ====
`timescale 1ns/1ps
`include "dpd_defines.svh"

module dpd_combiner (
    input  logic            up_clk,
    input  logic            up_rstn,
    input  dpd_pkg::iq_t    prods [`DPD_LUT_COUNT],
    input  dpd_pkg::iq_t    tu,
    input  logic            tu_enable,
    input  logic            bypass,
    output dpd_pkg::iq_t    tx,
    output logic            tx_valid
);

    // bypass path matches the row latency, output reg adds the last cycle
    dpd_pkg::iq_t                   tu_dly [`DPD_ACT_LATENCY-1];
    logic [`DPD_ACT_LATENCY-1:0]    en_dly;
    dpd_pkg::iq_t                   sum;

    always_comb begin
        sum = '0;
        for (int k = 0; k < `DPD_LUT_COUNT; k++) begin
            sum.i = sum.i + prods[k].i;     // wraps at 16 bits
            sum.q = sum.q + prods[k].q;
        end
    end

    always_ff @(posedge up_clk) begin
        if (!up_rstn) begin
            for (int n = 0; n < `DPD_ACT_LATENCY-1; n++) begin
                tu_dly[n] <= '0;
            end
            en_dly <= '0;
            tx     <= '0;
        end else begin
            tu_dly[0] <= tu;
            for (int n = 1; n < `DPD_ACT_LATENCY-1; n++) begin
                tu_dly[n] <= tu_dly[n-1];
            end
            en_dly <= {en_dly[`DPD_ACT_LATENCY-2:0], tu_enable};
            tx     <= bypass ? tu_dly[`DPD_ACT_LATENCY-2] : sum;
        end
    end

    assign tx_valid = en_dly[`DPD_ACT_LATENCY-1];

endmodule

// ==== dpd_top.sv ====
`timescale 1ns/1ps
`include "dpd_defines.svh"

module dpd_top (
    input  logic                            up_clk,
    input  logic                            up_rstn,

    input  logic                            up_wreq,
    input  logic [`DPD_UP_ADDR_WIDTH-1:0]   up_waddr,
    input  logic [`DPD_UP_DATA_WIDTH-1:0]   up_wdata,
    output logic                            up_wack,
    input  logic                            up_rreq,
    input  logic [`DPD_UP_ADDR_WIDTH-1:0]   up_raddr,
    output logic [`DPD_UP_DATA_WIDTH-1:0]   up_rdata,
    output logic                            up_rack,

    input  logic                            tu_enable,
    input  dpd_pkg::iq_t                    tu,
    input  logic [`DPD_MAG_WIDTH-1:0]       mag,    // |tu|
    output dpd_pkg::iq_t                    tx,     // predistorted
    output logic                            tx_valid
);

    dpd_pkg::lut_cfg_t      lut_cfg;
    dpd_pkg::lut_word_u     cfg_rdata [`DPD_LUT_COUNT];
    dpd_pkg::iq_t           prods [`DPD_LUT_COUNT];
    logic                   bypass;

    dpd_regs u_regs (
        .up_clk    (up_clk),
        .up_rstn   (up_rstn),
        .up_wreq   (up_wreq),
        .up_waddr  (up_waddr),
        .up_wdata  (up_wdata),
        .up_wack   (up_wack),
        .up_rreq   (up_rreq),
        .up_raddr  (up_raddr),
        .up_rdata  (up_rdata),
        .up_rack   (up_rack),
        .lut_cfg   (lut_cfg),
        .cfg_rdata (cfg_rdata),
        .bypass    (bypass)
    );

    // row k sees the sample from k cycles back
    generate
        for (genvar k = 0; k < `DPD_LUT_COUNT; k++) begin : gen_row
            dpd_lut_row #(
                .TAP(k)
            ) u_row (
                .up_clk    (up_clk),
                .up_rstn   (up_rstn),
                .tu        (tu),
                .mag       (mag),
                .lut_cfg   (lut_cfg),
                .cfg_rdata (cfg_rdata[k]),
                .prod      (prods[k])
            );
        end
    endgenerate

    dpd_combiner u_combiner (
        .up_clk    (up_clk),
        .up_rstn   (up_rstn),
        .prods     (prods),
        .tu        (tu),
        .tu_enable (tu_enable),
        .bypass    (bypass),
        .tx        (tx),
        .tx_valid  (tx_valid)
    );

endmodule

// ==== tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int period_ns = 8
) (
    output logic up_clk
);

    initial begin
        up_clk = 1'b0;
        forever #(period_ns / 2.0) up_clk = ~up_clk;
    end

endmodule

// ==== tb_dpd.sv ====
`timescale 1ns/1ps
`include "dpd_defines.svh"

module tb_dpd;

    localparam int clk_period   = 8;
    localparam int lat          = `DPD_ACT_LATENCY;
    localparam int lut_depth    = 2**`DPD_MAG_WIDTH;
    localparam int wr_ack_cyc   = 1;
    localparam int rd_ack_cyc   = 2;
    localparam int ack_limit    = 8;
    localparam int n_reg_iter   = 24;
    localparam int n_unmapped   = 16;
    localparam int n_lut_upd    = 32;
    localparam int n_samples    = 500;
    localparam int n_byp_samp   = 200;
    localparam int n_bus        = 4 + 4*n_reg_iter + n_unmapped + 2*`DPD_LUT_COUNT*lut_depth
                                  + n_lut_upd*(1 + `DPD_LUT_COUNT) + 1;
    localparam int n_cycles     = 7 + 4*n_bus + n_samples + n_byp_samp + 2*(lat + 1);
    localparam int timeout_ns   = 2 * n_cycles * clk_period;     // 2x margin

    // major 1, minor 1, patch 0x61
    localparam logic [`DPD_UP_DATA_WIDTH-1:0] ip_version = 32'h0001_0161;

    logic                           up_clk;
    logic                           up_rstn;
    logic                           up_wreq;
    logic [`DPD_UP_ADDR_WIDTH-1:0]  up_waddr;
    logic [`DPD_UP_DATA_WIDTH-1:0]  up_wdata;
    logic                           up_wack;
    logic                           up_rreq;
    logic [`DPD_UP_ADDR_WIDTH-1:0]  up_raddr;
    logic [`DPD_UP_DATA_WIDTH-1:0]  up_rdata;
    logic                           up_rack;
    logic                           tu_enable;
    dpd_pkg::iq_t                   tu;
    logic [`DPD_MAG_WIDTH-1:0]      mag;
    dpd_pkg::iq_t                   tx;
    logic                           tx_valid;

    // reference model state
    integer                         seed = 32'h1f06;
    logic [`DPD_UP_DATA_WIDTH-1:0]  scratch_model;
    logic [`DPD_UP_DATA_WIDTH-1:0]  bypass_model;
    dpd_pkg::lut_word_u             lut_model [`DPD_LUT_COUNT][lut_depth];
    dpd_pkg::iq_t                   hist_tu [`DPD_LUT_COUNT];   // [0] is newest
    logic [`DPD_MAG_WIDTH-1:0]      hist_mag [`DPD_LUT_COUNT];
    dpd_pkg::iq_t                   exp_tx_q [$];
    bit                             exp_valid_q [$];

    tb_clkgen #(.period_ns(clk_period)) u_clkgen (.up_clk(up_clk));

    dpd_top uut (
        .up_clk    (up_clk),
        .up_rstn   (up_rstn),
        .up_wreq   (up_wreq),
        .up_waddr  (up_waddr),
        .up_wdata  (up_wdata),
        .up_wack   (up_wack),
        .up_rreq   (up_rreq),
        .up_raddr  (up_raddr),
        .up_rdata  (up_rdata),
        .up_rack   (up_rack),
        .tu_enable (tu_enable),
        .tu        (tu),
        .mag       (mag),
        .tx        (tx),
        .tx_valid  (tx_valid)
    );

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [`DPD_UP_DATA_WIDTH-1:0] exp,
                              input logic [`DPD_UP_DATA_WIDTH-1:0] got);
        if (got !== exp) begin
            $display("Fail %s expected 0x%h got 0x%h", name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_iq(input string name, input dpd_pkg::iq_t exp, input dpd_pkg::iq_t got);
        if (got !== exp) begin
            $display("Fail %s expected 0x%h got 0x%h", name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input bit exp, input bit got);
        if (got !== exp) begin
            $display("Fail %s expected 0x%h got 0x%h", name, exp, got);
            abort_run();
        end
    endtask

    function automatic logic [`DPD_UP_ADDR_WIDTH-1:0] reg_addr(input int off);
        return {1'b0, off[`DPD_UP_ADDR_WIDTH-2:0]};
    endfunction

    function automatic logic [`DPD_UP_ADDR_WIDTH-1:0] lut_addr(input int id, input int entry);
        return {1'b1, id[`DPD_LUT_SEL_WIDTH-1:0], entry[`DPD_MAG_WIDTH-1:0]};
    endfunction

    // bus tasks start and end right after a rising edge
    task automatic do_write(input logic [`DPD_UP_ADDR_WIDTH-1:0] addr,
                            input logic [`DPD_UP_DATA_WIDTH-1:0] data);
        int cyc;
        up_wreq  <= 1'b1;
        up_waddr <= addr;
        up_wdata <= data;
        @(posedge up_clk);
        up_wreq <= 1'b0;
        cyc = 0;
        while (!up_wack && cyc < ack_limit) begin
            @(posedge up_clk);
            cyc++;
        end
        if (!up_wack) begin
            $display("write to address 0x%h was never acknowledged", addr);
            abort_run();
        end
        check_word("up_wack latency", wr_ack_cyc, cyc);
    endtask

    task automatic do_read(input logic [`DPD_UP_ADDR_WIDTH-1:0] addr,
                           output logic [`DPD_UP_DATA_WIDTH-1:0] data);
        int cyc;
        up_rreq  <= 1'b1;
        up_raddr <= addr;
        @(posedge up_clk);
        up_rreq <= 1'b0;
        cyc = 0;
        while (!up_rack && cyc < ack_limit) begin
            check_word("up_rdata", '0, up_rdata);   // zero while no ack
            @(posedge up_clk);
            cyc++;
        end
        if (!up_rack) begin
            $display("read from address 0x%h was never acknowledged", addr);
            abort_run();
        end
        check_word("up_rack latency", rd_ack_cyc, cyc);
        data = up_rdata;
    endtask

    task automatic expect_read(input logic [`DPD_UP_ADDR_WIDTH-1:0] addr,
                               input logic [`DPD_UP_DATA_WIDTH-1:0] exp, input string name);
        logic [`DPD_UP_DATA_WIDTH-1:0] got;
        do_read(addr, got);
        check_word(name, exp, got);
    endtask

    // sample times gain, scaled by the fraction bits and wrapped to 16 bits
    function automatic dpd_pkg::iq_t gain_mult(input dpd_pkg::iq_t s, input dpd_pkg::iq_t g);
        longint       re;
        longint       im;
        dpd_pkg::iq_t r;
        re = longint'(s.i) * longint'(g.i) - longint'(s.q) * longint'(g.q);
        im = longint'(s.i) * longint'(g.q) + longint'(s.q) * longint'(g.i);
        re = re >>> `DPD_FRAC_BITS;
        im = im >>> `DPD_FRAC_BITS;
        r.i = re[`DPD_IQ_WIDTH-1:0];
        r.q = im[`DPD_IQ_WIDTH-1:0];
        return r;
    endfunction

    function automatic dpd_pkg::iq_t model_tx();
        dpd_pkg::iq_t acc;
        dpd_pkg::iq_t p;
        acc = '0;
        if (bypass_model[0]) begin
            return hist_tu[0];
        end
        for (int k = 0; k < `DPD_LUT_COUNT; k++) begin
            p = gain_mult(hist_tu[k], lut_model[k][hist_mag[k]].iq);
            acc.i = acc.i + p.i;
            acc.q = acc.q + p.q;
        end
        return acc;
    endfunction

    task automatic stream_samples(input int n);
        dpd_pkg::iq_t               s;
        logic [`DPD_MAG_WIDTH-1:0]  m;
        logic                       en;
        exp_tx_q.delete();
        exp_valid_q.delete();
        // idle inputs before the stream, one extra for the drive edge
        repeat (lat + 1) begin
            exp_tx_q.push_back('0);
            exp_valid_q.push_back(1'b0);
        end
        for (int i = 0; i < n + lat + 1; i++) begin
            @(posedge up_clk);
            check_iq("tx", exp_tx_q.pop_front(), tx);
            check_bit("tx_valid", exp_valid_q.pop_front(), tx_valid);
            if (i < n) begin
                s  = $random(seed);
                m  = $random(seed);
                en = $random(seed);
            end else begin
                s  = '0;    // drain, leaves the history at zero
                m  = '0;
                en = 1'b0;
            end
            tu        <= s;
            mag       <= m;
            tu_enable <= en;
            for (int k = `DPD_LUT_COUNT - 1; k > 0; k--) begin
                hist_tu[k]  = hist_tu[k-1];
                hist_mag[k] = hist_mag[k-1];
            end
            hist_tu[0]  = s;
            hist_mag[0] = m;
            exp_tx_q.push_back(model_tx());
            exp_valid_q.push_back(en);
        end
    endtask

    initial begin
        #(timeout_ns);
        $display("simulation timed out after %0d ns", timeout_ns);
        abort_run();
    end

    initial begin
        logic [`DPD_UP_DATA_WIDTH-1:0] d;
        int k;
        int e;
        int off;
        up_rstn   = 1'b0;
        up_wreq   = 1'b0;
        up_waddr  = '0;
        up_wdata  = '0;
        up_rreq   = 1'b0;
        up_raddr  = '0;
        tu_enable = 1'b0;
        tu        = '0;
        mag       = '0;
        scratch_model = '0;
        bypass_model  = '0;
        for (int n = 0; n < `DPD_LUT_COUNT; n++) begin
            hist_tu[n]  = '0;
            hist_mag[n] = '0;
        end

        repeat (5) @(posedge up_clk);
        check_iq("tx", '0, tx);
        check_bit("tx_valid", 1'b0, tx_valid);
        check_bit("up_wack", 1'b0, up_wack);
        check_bit("up_rack", 1'b0, up_rack);
        up_rstn <= 1'b1;
        @(posedge up_clk);
        expect_read(reg_addr(`DPD_REG_VERSION), ip_version, "version");
        expect_read(reg_addr(`DPD_REG_SCRATCH), '0, "scratch");
        expect_read(reg_addr(`DPD_REG_BYPASS), '0, "bypass");

        for (int i = 0; i < n_reg_iter; i++) begin
            d = $random(seed);
            do_write(reg_addr(`DPD_REG_SCRATCH), d);
            scratch_model = d;
            expect_read(reg_addr(`DPD_REG_SCRATCH), scratch_model, "scratch");
            d = $random(seed);
            do_write(reg_addr(`DPD_REG_BYPASS), d);
            bypass_model = d;
            expect_read(reg_addr(`DPD_REG_BYPASS), bypass_model, "bypass");
        end
        for (int i = 0; i < n_unmapped; i++) begin
            off = `DPD_REG_BYPASS + 1 +
                  ($unsigned($random(seed)) % (2**(`DPD_UP_ADDR_WIDTH-1) - `DPD_REG_BYPASS - 1));
            expect_read(reg_addr(off), '0, $sformatf("unmapped reg %0d", off));
        end

        // fill every lut so the datapath never reads an unwritten entry
        for (k = 0; k < `DPD_LUT_COUNT; k++) begin
            for (e = 0; e < lut_depth; e++) begin
                d = $random(seed);
                do_write(lut_addr(k, e), d);
                lut_model[k][e].raw = d;
            end
        end
        for (k = 0; k < `DPD_LUT_COUNT; k++) begin
            for (e = 0; e < lut_depth; e++) begin
                expect_read(lut_addr(k, e), lut_model[k][e].raw, $sformatf("lut%0d[%0d]", k, e));
            end
        end
        for (int i = 0; i < n_lut_upd; i++) begin
            k = $unsigned($random(seed)) % `DPD_LUT_COUNT;
            e = $unsigned($random(seed)) % lut_depth;
            d = $random(seed);
            do_write(lut_addr(k, e), d);
            lut_model[k][e].raw = d;
            for (int j = 0; j < `DPD_LUT_COUNT; j++) begin
                expect_read(lut_addr(j, e), lut_model[j][e].raw, $sformatf("lut%0d[%0d]", j, e));
            end
        end

        do_write(reg_addr(`DPD_REG_BYPASS), '0);
        bypass_model = '0;
        stream_samples(n_samples);

        do_write(reg_addr(`DPD_REG_BYPASS), 32'h1);
        bypass_model = 32'h1;
        stream_samples(n_byp_samp);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+.
dpd_pkg.sv
dpd_regs.sv
dpd_lut_row.sv
dpd_combiner.sv
dpd_top.sv
tb_clkgen.sv
tb_dpd.sv
